// File: timeOfDay.f
common/todPkg.sv
common/busPkg.sv
src/tickPrescaler.sv
clock/clockRegisterFile.sv
clock/bcdTimeCounter.sv
src/statusLineChars.sv
src/timeOfDay.sv
tests/tb_timeOfDay.sv

// File: run.sh
#!/bin/sh
# Build the time-of-day testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module tb_timeOfDay -f timeOfDay.f \
	-o simTimeOfDay > build.log 2>&1 \
	&& ./obj_dir/simTimeOfDay > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/tb_timeOfDay.sv
// Directed testbench for the time-of-day clock, bus reads and writes on H_SYNC
// Runs reset, preset load, carry, status-line and debounce tests, then prints a summary
`timescale 1ns/1ps
`default_nettype none

module tb_timeOfDay
	import todPkg::*, busPkg::*;
();

	localparam int TickLines = 16;			// Short second for simulation
	localparam int TickTimeout = 3 * TickLines;	// Polls before giving up on a tick

	logic H_SYNC;
	logic RESET_N;
	regAddr_t regSel;
	logic regWrite;
	busData_t regWrData;
	column_t charCol;
	busData_t regRdData;
	busData_t charCode;

	int dataErrors = 0;
	int charErrors = 0;
	int digitErrors = 0;
	int waitErrors = 0;
	logic [31:0] rngState = 32'd91;

	timeOfDay #(
		.LinesPerSecond(TickLines)
	) dut_i (
		.H_SYNC(H_SYNC),
		.RESET_N(RESET_N),
		.regSel(regSel),
		.regWrite(regWrite),
		.regWrData(regWrData),
		.charCol(charCol),
		.regRdData(regRdData),
		.charCode(charCode)
	);

	initial
	begin
		H_SYNC = 1'b0;
		forever #4 H_SYNC = ~H_SYNC;		// 8 ns line period
	end

	// Watchdog for the whole run
	initial
	begin
		#200000;
		$display("simulation did not finish within the time limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int randomBelow(input int range);
		rngState = xorshift(rngState);
		return int'(rngState % range);
	endfunction

	task automatic checkData(input string name, input busData_t got, input busData_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			dataErrors = dataErrors + 1;
		end
	endtask

	task automatic checkChar(input string name, input busData_t got, input busData_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			charErrors = charErrors + 1;
		end
	endtask

	task automatic checkDigit(input string name, input bcdDigit_t got, input bcdDigit_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			digitErrors = digitErrors + 1;
		end
	endtask

	// One bus read, sampled mid-cycle
	task automatic readReg(input regAddr_t addr, output busData_t value);
		@(posedge H_SYNC);
		regSel <= addr;
		regWrite <= 1'b0;
		@(negedge H_SYNC);
		value = regRdData;
	endtask

	task automatic writeReg(input regAddr_t addr, input busData_t data);
		@(posedge H_SYNC);
		regSel <= addr;
		regWrData <= data;
		regWrite <= 1'b1;				// Held until the next access
	endtask

	task automatic readChar(input int col, output busData_t value);
		@(posedge H_SYNC);
		charCol <= column_t'(col);
		@(negedge H_SYNC);
		value = charCode;
	endtask

	// Six preset writes back to back, hours tens last with the flag
	task automatic writePreset(input int h, input int m, input int sTens, input int sOnes,
		input logic flag);
		writeReg(RegSecOnes, busData_t'(sOnes));
		writeReg(RegSecTens, busData_t'(sTens));
		writeReg(RegMinOnes, busData_t'(m % 10));
		writeReg(RegMinTens, busData_t'(m / 10));
		writeReg(RegHourOnes, busData_t'(h % 10));
		writeReg(RegHourTens, busData_t'(h / 10) | (busData_t'(flag) << LoadFlagBit));
		@(posedge H_SYNC);
		regWrite <= 1'b0;
	endtask

	task automatic releaseLoad(input int h);
		writeReg(RegHourTens, busData_t'(h / 10));	// Flag bit clear
		@(posedge H_SYNC);
		regWrite <= 1'b0;
	endtask

	// Polls seconds ones until it moves, returns the new digit
	task automatic waitSecondsChange(output bcdDigit_t newOnes);
		busData_t first;
		busData_t value;
		int polls;
		readReg(RegSecOnes, first);
		value = first;
		polls = 0;
		while (value == first && polls < TickTimeout)
		begin
			readReg(RegSecOnes, value);
			polls = polls + 1;
		end
		if (value == first)
		begin
			$display("timeout while waiting for the seconds register to change");
			waitErrors = waitErrors + 1;
		end
		newOnes = bcdDigit_t'(value[3:0]);
	endtask

	// Load a time and return right after the tick that copied it
	task automatic loadTime(input int h, input int m, input int s);
		bcdDigit_t cur;
		bcdDigit_t seen;
		int marker;
		waitSecondsChange(cur);				// Align just after a tick
		marker = 0;
		while (marker == int'(cur) || marker == s % 10)
			marker = marker + 1;
		writePreset(h, m, s / 10, marker, 1'b1);	// Marker makes the load visible
		waitSecondsChange(seen);
		writePreset(h, m, s / 10, s % 10, 1'b1);
		waitSecondsChange(seen);
	endtask

	task automatic timeReadback(input string label, input int h, input int m, input int s);
		busData_t value;
		readReg(RegSecOnes, value);
		checkDigit({label, " secOnes"}, bcdDigit_t'(value[3:0]), bcdDigit_t'(s % 10));
		readReg(RegSecTens, value);
		checkDigit({label, " secTens"}, bcdDigit_t'(value[3:0]), bcdDigit_t'(s / 10));
		readReg(RegMinOnes, value);
		checkDigit({label, " minOnes"}, bcdDigit_t'(value[3:0]), bcdDigit_t'(m % 10));
		readReg(RegMinTens, value);
		checkDigit({label, " minTens"}, bcdDigit_t'(value[3:0]), bcdDigit_t'(m / 10));
		readReg(RegHourOnes, value);
		checkDigit({label, " hourOnes"}, bcdDigit_t'(value[3:0]), bcdDigit_t'(h % 10));
		readReg(RegHourTens, value);
		checkData({label, " hourTens"}, value, busData_t'(h / 10));	// No flag bit
	endtask

	// Time of day plus one second, through a seconds count
	task automatic nextSecond(input int h, input int m, input int s,
		output int nh, output int nm, output int ns);
		int total;
		total = (h * 3600 + m * 60 + s + 1) % 86400;
		nh = total / 3600;
		nm = (total / 60) % 60;
		ns = total % 60;
	endtask

	function automatic busData_t expectedChar(input int col, input int h, input int m,
		input int s);
		int digits[8];
		int pos;
		busData_t code;
		digits = '{h / 10, h % 10, -1, m / 10, m % 10, -1, s / 10, s % 10};	// -1 is a colon
		pos = col - int'(StatusColFirst);
		if (pos < 0 || pos > 7)
			code = AsciiSpace;
		else if (digits[pos] < 0)
			code = AsciiColon;
		else
			code = AsciiZero + busData_t'(digits[pos]);
		return code;
	endfunction

	task automatic statusLineText(input int h, input int m, input int s, input int firstCol,
		input int lastCol);
		busData_t value;
		for (int col = firstCol; col <= lastCol; col++)
		begin
			readChar(col, value);
			checkChar($sformatf("charCode col %0d", col), value, expectedChar(col, h, m, s));
		end
	endtask

	// Must finish inside the first second after reset
	task automatic resetState();
		busData_t value;
		for (int r = 1; r <= 6; r++)
		begin
			readReg(regAddr_t'(r), value);
			checkData($sformatf("regRdData reg %0d after reset", r), value, 8'h00);
		end
		readReg(RegUnused, value);
		checkData("regRdData reg 7", value, 8'hFF);
		statusLineText(0, 0, 0, 28, 35);
		readChar(0, value);
		checkChar("charCode col 0", value, AsciiSpace);
	endtask

	task automatic presetLoad();
		int h;
		int m;
		int s;
		int nh;
		int nm;
		int ns;
		bcdDigit_t seen;
		h = randomBelow(24);
		m = randomBelow(60);
		s = randomBelow(60);
		loadTime(h, m, s);
		timeReadback("preset", h, m, s);
		releaseLoad(h);
		waitSecondsChange(seen);
		nextSecond(h, m, s, nh, nm, ns);
		timeReadback("after release", nh, nm, ns);
	endtask

	task automatic carryStep(input string label, input int h, input int m, input int s,
		input int eh, input int em, input int es);
		bcdDigit_t seen;
		loadTime(h, m, s);
		releaseLoad(h);
		waitSecondsChange(seen);
		timeReadback(label, eh, em, es);
	endtask

	task automatic debounceRate();
		busData_t first;
		busData_t second;
		readReg(RegDebounce, first);
		repeat (19) @(posedge H_SYNC);
		readReg(RegDebounce, second);			// 20 lines after the first
		checkData("debounceCount delta", second - first, 8'd10);
	endtask

	initial
	begin
		RESET_N <= 1'b0;
		regSel <= '0;
		regWrite <= 1'b0;
		regWrData <= '0;
		charCol <= '0;
		repeat (3) @(posedge H_SYNC);
		RESET_N <= 1'b1;

		resetState();
		presetLoad();
		carryStep("09:59:59 carry", 9, 59, 59, 10, 0, 0);
		carryStep("23:59:59 wrap", 23, 59, 59, 0, 0, 0);
		carryStep("19:59:59 carry", 19, 59, 59, 20, 0, 0);
		loadTime(12, 34, 56);
		statusLineText(12, 34, 56, 27, 36);
		releaseLoad(12);
		debounceRate();

		$display("errors: data %0d, char %0d, digit %0d, wait %0d",
			dataErrors, charErrors, digitErrors, waitErrors);
		if (dataErrors + charErrors + digitErrors + waitErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/timeOfDay.sv
// Time-of-day clock top level, prescaler, register bank, BCD counter and status text
// Bus and character ports run on H_SYNC, LinesPerSecond sets the line rate
`timescale 1ns/1ps
`default_nettype none

module timeOfDay
	import todPkg::*, busPkg::*;
#(
	parameter int LinesPerSecond = todPkg::LinesPerSecond
)
(
	input wire logic H_SYNC,
	input wire logic RESET_N,
	input wire regAddr_t regSel,
	input wire logic regWrite,
	input wire busData_t regWrData,
	input wire column_t charCol,
	output busData_t regRdData,
	output busData_t charCode
);

	logic secondTick;
	busData_t debounceCount;
	logic loadFlag;

	// Preset fields
	bcdDigit_t setSecOnes;
	secTens_t setSecTens;
	bcdDigit_t setMinOnes;
	secTens_t setMinTens;
	bcdDigit_t setHourOnes;
	hourTens_t setHourTens;

	// Running time, to readback and status line
	bcdDigit_t secOnes;
	secTens_t secTens;
	bcdDigit_t minOnes;
	secTens_t minTens;
	bcdDigit_t hourOnes;
	hourTens_t hourTens;

	tickPrescaler #(
		.LinesPerSecond(LinesPerSecond)
	) prescaler_i (
		.H_SYNC(H_SYNC),
		.RESET_N(RESET_N),
		.secondTick(secondTick),
		.debounceCount(debounceCount)
	);

	clockRegisterFile regFile_i (
		.H_SYNC(H_SYNC),
		.RESET_N(RESET_N),
		.regSel(regSel),
		.regWrite(regWrite),
		.regWrData(regWrData),
		.regRdData(regRdData),
		.debounceCount(debounceCount),
		.secOnes(secOnes),
		.secTens(secTens),
		.minOnes(minOnes),
		.minTens(minTens),
		.hourOnes(hourOnes),
		.hourTens(hourTens),
		.setSecOnes(setSecOnes),
		.setSecTens(setSecTens),
		.setMinOnes(setMinOnes),
		.setMinTens(setMinTens),
		.setHourOnes(setHourOnes),
		.setHourTens(setHourTens),
		.loadFlag(loadFlag)
	);

	bcdTimeCounter counter_i (
		.H_SYNC(H_SYNC),
		.RESET_N(RESET_N),
		.secondTick(secondTick),
		.loadFlag(loadFlag),
		.setSecOnes(setSecOnes),
		.setSecTens(setSecTens),
		.setMinOnes(setMinOnes),
		.setMinTens(setMinTens),
		.setHourOnes(setHourOnes),
		.setHourTens(setHourTens),
		.secOnes(secOnes),
		.secTens(secTens),
		.minOnes(minOnes),
		.minTens(minTens),
		.hourOnes(hourOnes),
		.hourTens(hourTens)
	);

	statusLineChars chars_i (
		.charCol(charCol),
		.secOnes(secOnes),
		.secTens(secTens),
		.minOnes(minOnes),
		.minTens(minTens),
		.hourOnes(hourOnes),
		.hourTens(hourTens),
		.charCode(charCode)
	);

endmodule

`default_nettype wire

// File: src/statusLineChars.sv
// Status-line text of the running time, read by the video fetcher per column
// Columns 28 to 35 give "HH:MM:SS", any other column gives a space
`timescale 1ns/1ps
`default_nettype none

module statusLineChars
	import todPkg::*, busPkg::*;
(
	input wire column_t charCol,
	input wire bcdDigit_t secOnes,
	input wire secTens_t secTens,
	input wire bcdDigit_t minOnes,
	input wire secTens_t minTens,
	input wire bcdDigit_t hourOnes,
	input wire hourTens_t hourTens,
	output busData_t charCode
);

	column_t colOffset;				// Position inside the time field

	// Digit to its ASCII code
	function automatic busData_t toAscii(input bcdDigit_t digit);
		return AsciiZero + {4'h0, digit};
	endfunction

	assign colOffset = charCol - StatusColFirst;	// Wraps high below the field

	always_comb
	begin
		case (colOffset)
			6'd0: charCode = toAscii(bcdDigit_t'(hourTens));
			6'd1: charCode = toAscii(hourOnes);
			6'd2: charCode = AsciiColon;
			6'd3: charCode = toAscii(bcdDigit_t'(minTens));
			6'd4: charCode = toAscii(minOnes);
			6'd5: charCode = AsciiColon;
			6'd6: charCode = toAscii(bcdDigit_t'(secTens));
			6'd7: charCode = toAscii(secOnes);
			default: charCode = AsciiSpace;		// Rest of the line blank
		endcase
	end

endmodule

`default_nettype wire

// File: clock/bcdTimeCounter.sv
// Running BCD time of day, 24-hour cycle, one step per seconds tick
// A set load flag copies the preset on every tick instead of counting
`timescale 1ns/1ps
`default_nettype none

module bcdTimeCounter
	import todPkg::*;
(
	input wire logic H_SYNC,
	input wire logic RESET_N,
	input wire logic secondTick,
	input wire logic loadFlag,

	// Preset from the register file
	input wire bcdDigit_t setSecOnes,
	input wire secTens_t setSecTens,
	input wire bcdDigit_t setMinOnes,
	input wire secTens_t setMinTens,
	input wire bcdDigit_t setHourOnes,
	input wire hourTens_t setHourTens,

	// Running time
	output bcdDigit_t secOnes,
	output secTens_t secTens,
	output bcdDigit_t minOnes,
	output secTens_t minTens,
	output bcdDigit_t hourOnes,
	output hourTens_t hourTens
);

	// Carry out of each digit, valid when the tick lands
	logic secOnesCarry;
	logic secTensCarry;
	logic minOnesCarry;
	logic minTensCarry;
	logic hourOnesCarry;
	logic dayWrap;

	// One BCD digit step, wraps to zero after lastValue
	function automatic bcdDigit_t stepDigit(
		input bcdDigit_t value,
		input bcdDigit_t lastValue,
		input logic carryIn
	);
		bcdDigit_t result;
		if (!carryIn)
			result = value;				// Hold
		else if (value == lastValue)
			result = DigitZero;
		else
			result = value + 1'b1;
		return result;
	endfunction

	// Ripple chain, seconds to hours
	assign secOnesCarry = (secOnes == DigitMax);
	assign secTensCarry = secOnesCarry && (secTens == SecTensMax);	// xx:xx:59
	assign minOnesCarry = secTensCarry && (minOnes == DigitMax);
	assign minTensCarry = minOnesCarry && (minTens == SecTensMax);	// xx:59:59
	assign hourOnesCarry = minTensCarry && (hourOnes == DigitMax);	// 09 or 19
	assign dayWrap = minTensCarry && (hourTens == HourTensMax)
		&& (hourOnes == DayLastHourOnes);	// 23:59:59

	always_ff @(posedge H_SYNC or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			secOnes <= DigitZero;
			secTens <= SecTensZero;
			minOnes <= DigitZero;
			minTens <= SecTensZero;
			hourOnes <= DigitZero;
			hourTens <= HourTensZero;
		end
		else if (secondTick)
		begin
			if (loadFlag)
			begin
				// Preset copy, repeats each tick while flag stays set
				secOnes <= setSecOnes;
				secTens <= setSecTens;
				minOnes <= setMinOnes;
				minTens <= setMinTens;
				hourOnes <= setHourOnes;
				hourTens <= setHourTens;
			end
			else
			begin
				secOnes <= stepDigit(secOnes, DigitMax, 1'b1);
				secTens <= secTens_t'(stepDigit(bcdDigit_t'(secTens),
					bcdDigit_t'(SecTensMax), secOnesCarry));
				minOnes <= stepDigit(minOnes, DigitMax, secTensCarry);
				minTens <= secTens_t'(stepDigit(bcdDigit_t'(minTens),
					bcdDigit_t'(SecTensMax), minOnesCarry));
				if (dayWrap)
				begin
					hourOnes <= DigitZero;		// Back to 00:00:00
					hourTens <= HourTensZero;
				end
				else
				begin
					hourOnes <= stepDigit(hourOnes, DigitMax, minTensCarry);
					hourTens <= hourTens + hourTens_t'(hourOnesCarry);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: clock/clockRegisterFile.sv
// Clock register bank on the bus, preset time and load flag on write
// Reads return the running time, the debounce count or FFh for the spare slot
`timescale 1ns/1ps
`default_nettype none

module clockRegisterFile
	import todPkg::*, busPkg::*;
(
	input wire logic H_SYNC,
	input wire logic RESET_N,

	// Bus side
	input wire regAddr_t regSel,
	input wire logic regWrite,
	input wire busData_t regWrData,
	output busData_t regRdData,

	// From prescaler
	input wire busData_t debounceCount,

	// Running time, read back only
	input wire bcdDigit_t secOnes,
	input wire secTens_t secTens,
	input wire bcdDigit_t minOnes,
	input wire secTens_t minTens,
	input wire bcdDigit_t hourOnes,
	input wire hourTens_t hourTens,

	// Preset time to the counter
	output bcdDigit_t setSecOnes,
	output secTens_t setSecTens,
	output bcdDigit_t setMinOnes,
	output secTens_t setMinTens,
	output bcdDigit_t setHourOnes,
	output hourTens_t setHourTens,
	output logic loadFlag
);

	// Write decode, lands on the next edge
	always_ff @(posedge H_SYNC or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			setSecOnes <= '0;
			setSecTens <= '0;
			setMinOnes <= '0;
			setMinTens <= '0;
			setHourOnes <= '0;
			setHourTens <= '0;
			loadFlag <= 1'b0;
		end
		else if (regWrite)
		begin
			case (regSel)
				RegSecOnes: setSecOnes <= regWrData[3:0];
				RegSecTens: setSecTens <= regWrData[2:0];
				RegMinOnes: setMinOnes <= regWrData[3:0];
				RegMinTens: setMinTens <= regWrData[2:0];
				RegHourOnes: setHourOnes <= regWrData[3:0];
				RegHourTens:
				begin
					setHourTens <= regWrData[1:0];
					loadFlag <= regWrData[LoadFlagBit];	// Copy preset on tick
				end
				default: ;					// Debounce and spare slot are read only
			endcase
		end
	end

	// Read mux, zero padded, no load flag in the read
	always_comb
	begin
		case (regSel)
			RegDebounce: regRdData = debounceCount;
			RegSecOnes: regRdData = {4'h0, secOnes};
			RegSecTens: regRdData = {5'h00, secTens};
			RegMinOnes: regRdData = {4'h0, minOnes};
			RegMinTens: regRdData = {5'h00, minTens};
			RegHourOnes: regRdData = {4'h0, hourOnes};
			RegHourTens: regRdData = {6'h00, hourTens};
			RegUnused: regRdData = UnusedRead;
			default: regRdData = UnusedRead;
		endcase
	end

endmodule

`default_nettype wire

// File: src/tickPrescaler.sv
// Sync line prescaler, one pulse per second from H_SYNC
// Also runs the debounce counter that software polls through register 0
`timescale 1ns/1ps
`default_nettype none

module tickPrescaler
	import todPkg::*, busPkg::*;
#(
	parameter int LinesPerSecond = todPkg::LinesPerSecond
)
(
	input wire logic H_SYNC,
	input wire logic RESET_N,
	output logic secondTick,			// One line wide
	output busData_t debounceCount
);

	lineCount_t lineCount;
	logic lastLine;

	// Final line of the second
	assign lastLine = (lineCount == lineCount_t'(LinesPerSecond - 1));
	assign secondTick = lastLine;

	always_ff @(posedge H_SYNC or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			lineCount <= '0;
			debounceCount <= '0;
		end
		else
		begin
			if (lastLine)
				lineCount <= '0;			// Wrap
			else
				lineCount <= lineCount + 1'b1;

			// Odd to even, every second line
			if (lineCount[0])
				debounceCount <= debounceCount + 1'b1;	// Wraps at 256
		end
	end

endmodule

`default_nettype wire

// File: common/busPkg.sv
// Register bus and status-line definitions for the time-of-day clock
// Register map, character codes and bus widths shared by the bus-facing blocks
`default_nettype none

package busPkg;

	typedef logic [2:0] regAddr_t;		// Register select
	typedef logic [7:0] busData_t;		// Register and character data
	typedef logic [5:0] column_t;		// Status-line column

	// Clock register map, eight bytes
	localparam regAddr_t RegDebounce = 3'd0;		// Free-running debounce count
	localparam regAddr_t RegSecOnes = 3'd1;
	localparam regAddr_t RegSecTens = 3'd2;
	localparam regAddr_t RegMinOnes = 3'd3;
	localparam regAddr_t RegMinTens = 3'd4;
	localparam regAddr_t RegHourOnes = 3'd5;
	localparam regAddr_t RegHourTens = 3'd6;		// Also holds the load flag
	localparam regAddr_t RegUnused = 3'd7;

	// Load flag position in the hours tens byte
	localparam int LoadFlagBit = 7;

	// First column of "HH:MM:SS"
	localparam column_t StatusColFirst = 6'd28;

	// Characters
	localparam busData_t AsciiZero = 8'h30;
	localparam busData_t AsciiColon = 8'h3A;
	localparam busData_t AsciiSpace = 8'h20;

	// Read value of the empty register slot
	localparam busData_t UnusedRead = 8'hFF;

endpackage

`default_nettype wire

// File: common/todPkg.sv
// Time-keeping types and limits for the time-of-day clock
// Imported by the prescaler, the register file, the BCD counter and the formatter
`default_nettype none

package todPkg;

	// BCD field widths
	typedef logic [3:0] bcdDigit_t;		// Ones digit of sec, min or hours
	typedef logic [2:0] secTens_t;		// Tens of sec or min, 0..5
	typedef logic [1:0] hourTens_t;		// Tens of hours, 0..2

	// Sync line prescaler
	typedef logic [15:0] lineCount_t;

	// Sync lines per second
	// Counter wraps after DC9B, so one second is DC9B+1 lines
	localparam int LinesPerSecond = 56476;

	// Last value of a ones digit before it wraps
	localparam bcdDigit_t DigitMax = 4'd9;

	// Last value of seconds or minutes tens
	localparam secTens_t SecTensMax = 3'd5;

	// Hours tens in the twenties
	localparam hourTens_t HourTensMax = 2'd2;

	// Hours ones at 23, where the day wraps
	localparam bcdDigit_t DayLastHourOnes = 4'd3;

	// Midnight values
	localparam bcdDigit_t DigitZero = 4'd0;
	localparam secTens_t SecTensZero = 3'd0;
	localparam hourTens_t HourTensZero = 2'd0;

endpackage

`default_nettype wire
